/* hdl/sscan_pkg.sv */
// Shadow-scan snapshot definitions
// Field widths of the core status buses, the packed snapshot layout and
// the constants of the capture and clock-crossing logic

package sscan_pkg;

  // Widths of the four status buses coming from the core units
  localparam int IFQ_W = 4;
  localparam int TLU_W = 63;
  localparam int LSU_W = 16;
  localparam int SWL_W = 11;

  // Total width of one frozen snapshot
  localparam int SNAP_W = IFQ_W + TLU_W + LSU_W + SWL_W;

  // Flops in the toggle synchroniser on the test clock side
  localparam int SYNC_STAGES = 2;

  // Snap counter width, wraps on overflow
  localparam int CNT_W = 16;

  // Snapshot layout from MSB down
  // The fetch-queue data sits on top so it is the first bit out of the
  // serial scan port, and thread state ends up in the LSBs
  typedef struct packed {
    logic [IFQ_W-1:0] ifq;
    logic [TLU_W-1:0] tlu;
    logic [LSU_W-1:0] lsu;
    logic [SWL_W-1:0] swl;
  } sscan_snap_t;

endpackage

/* hdl/sscan_axi_pkg.sv */
// AXI4-Lite definitions for the shadow-scan register block
// Channel payload structs, response codes and the register map

package sscan_axi_pkg;

  localparam int AXIL_AW = 8;
  localparam int AXIL_DW = 32;
  localparam int AXIL_SW = AXIL_DW / 8;

  // Write and read address channel payloads
  typedef struct packed {
    logic [AXIL_AW-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [AXIL_AW-1:0] addr;
  } axil_ar_t;

  // Write data channel payload, one strobe bit per byte lane
  typedef struct packed {
    logic [AXIL_DW-1:0] data;
    logic [AXIL_SW-1:0] strb;
  } axil_w_t;

  // Only the two codes this slave ever returns
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  typedef struct packed {
    logic [AXIL_DW-1:0] data;
    axil_resp_e         resp;
  } axil_r_t;

  // Register map, byte addresses
  typedef enum logic [AXIL_AW-1:0] {
    REG_CTRL  = 8'h00,
    REG_COUNT = 8'h04,
    REG_DATA0 = 8'h08,
    REG_DATA1 = 8'h0C,
    REG_DATA2 = 8'h10
  } sscan_reg_e;

endpackage

/* hdl/sscan_snap_capture.sv */
// Snapshot capture in the core clock domain
// Registers the snap request, then freezes the status buses into the
// capture register one cycle later. Every capture flips a toggle for the
// test clock side and bumps a wrapping snap counter

`timescale 1ns/1ps

module sscan_snap_capture
  import sscan_pkg::*;
(
  input  logic             rclk,
  input  logic             rst_n,
  input  logic             snap_req,
  input  sscan_snap_t      status_in,
  output sscan_snap_t      cap_data,
  output logic             cap_toggle,
  output logic [CNT_W-1:0] snap_count
);

  // Request flop, mirrors the snap flop in front of the capture register
  logic snap_f;

  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      snap_f <= 1'b0;
    end else begin
      snap_f <= snap_req;
    end
  end

  // Enabled capture register
  // Status is sampled on the edge after the request was seen, so the
  // snapshot lands two edges after the request edge
  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      cap_data <= '0;
    end else if (snap_f) begin
      cap_data <= status_in;
    end
  end

  // Each capture flips the toggle once
  // The test clock side only looks for a change, so back-to-back snaps
  // must be spaced wider than the synchroniser to be seen separately
  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      cap_toggle <= 1'b0;
    end else if (snap_f) begin
      cap_toggle <= ~cap_toggle;
    end
  end

  // Counts every capture, pin and software alike, and wraps at the top
  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      snap_count <= '0;
    end else if (snap_f) begin
      snap_count <= snap_count + 1'b1;
    end
  end

endmodule

/* hdl/sscan_tck_shadow.sv */
// Shadow scan register in the test clock domain
// Detects new captures through a toggle synchroniser, loads the frozen
// snapshot in parallel and shifts it out MSB first while scan enable is high

`timescale 1ns/1ps

module sscan_tck_shadow
  import sscan_pkg::*;
(
  input  logic        ctu_tck,
  input  logic        rst_n,
  input  logic        ctu_sscan_se,
  input  logic        cap_toggle,
  input  sscan_snap_t cap_data,
  output logic        sparc_sscan_so
);

  logic [SYNC_STAGES-1:0] tog_sync;
  logic                   tog_seen;
  logic                   new_cap;
  logic                   load_pend;
  logic                   do_load;
  logic [SNAP_W-1:0]      shadow_q;

  // Toggle synchroniser, bit 0 is the first flop after the crossing
  always_ff @(posedge ctu_tck or negedge rst_n) begin
    if (!rst_n) begin
      tog_sync <= '0;
    end else begin
      tog_sync <= {tog_sync[SYNC_STAGES-2:0], cap_toggle};
    end
  end

  // Last synchronised toggle value that has been acted on
  always_ff @(posedge ctu_tck or negedge rst_n) begin
    if (!rst_n) begin
      tog_seen <= 1'b0;
    end else begin
      tog_seen <= tog_sync[SYNC_STAGES-1];
    end
  end

  // Any change of the synchronised toggle marks one new capture
  assign new_cap = tog_sync[SYNC_STAGES-1] ^ tog_seen;

  // A capture can only be loaded while the chain is not shifting
  assign do_load = (new_cap || load_pend) && !ctu_sscan_se;

  // Remember a capture that arrived mid-shift until scan enable drops
  always_ff @(posedge ctu_tck or negedge rst_n) begin
    if (!rst_n) begin
      load_pend <= 1'b0;
    end else if (do_load) begin
      load_pend <= 1'b0;
    end else if (new_cap) begin
      load_pend <= 1'b1;
    end
  end

  // Shadow register
  // Shifting takes priority, so bits already in flight are never
  // overwritten by a snapshot that shows up during a scan
  always_ff @(posedge ctu_tck or negedge rst_n) begin
    if (!rst_n) begin
      shadow_q <= '0;
    end else if (ctu_sscan_se) begin
      shadow_q <= {shadow_q[SNAP_W-2:0], 1'b0};
    end else if (do_load) begin
      shadow_q <= cap_data;
    end
  end

  // Serial out is the MSB, so ifq leaves first
  assign sparc_sscan_so = shadow_q[SNAP_W-1];

endmodule

/* hdl/sscan_csr_axil.sv */
// AXI4-Lite register block of the shadow-scan path
// Software snap trigger, snap counter and a read window onto the frozen
// snapshot. One outstanding write and one outstanding read at a time

`timescale 1ns/1ps

module sscan_csr_axil
  import sscan_pkg::*;
  import sscan_axi_pkg::*;
(
  input  logic             rclk,
  input  logic             rst_n,
  // Write address and write data
  input  logic             axil_awvalid,
  output logic             axil_awready,
  input  axil_aw_t         axil_aw,
  input  logic             axil_wvalid,
  output logic             axil_wready,
  input  axil_w_t          axil_w,
  // Write response
  output logic             axil_bvalid,
  input  logic             axil_bready,
  output axil_resp_e       axil_bresp,
  // Read address and read data
  input  logic             axil_arvalid,
  output logic             axil_arready,
  input  axil_ar_t         axil_ar,
  output logic             axil_rvalid,
  input  logic             axil_rready,
  output axil_r_t          axil_r,
  // Capture side
  input  sscan_snap_t      cap_data,
  input  logic [CNT_W-1:0] snap_count,
  output logic             sw_snap
);

  logic              wr_acc;
  logic              wr_ctrl;
  axil_resp_e        wr_resp;
  logic              rd_acc;
  logic [SNAP_W-1:0] cap_bits;
  logic [AXIL_DW-1:0] rd_data;
  axil_resp_e        rd_resp;

  assign cap_bits = cap_data;

  // Address and data are taken together, and only when no write response
  // is still waiting for bready
  assign wr_acc       = axil_awvalid && axil_wvalid && !axil_bvalid;
  assign axil_awready = wr_acc;
  assign axil_wready  = wr_acc;

  // CTRL is the only writable register, everything else answers SLVERR
  assign wr_ctrl = (axil_aw.addr == REG_CTRL);
  assign wr_resp = wr_ctrl ? OKAY : SLVERR;

  // Software trigger, a single pulse in the accept cycle
  // Bit 0 only counts when its byte lane is strobed
  assign sw_snap = wr_acc && wr_ctrl && axil_w.strb[0] && axil_w.data[0];

  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      axil_bvalid <= 1'b0;
    end else if (wr_acc) begin
      axil_bvalid <= 1'b1;
    end else if (axil_bready) begin
      axil_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge rclk) begin
    if (wr_acc) begin
      axil_bresp <= wr_resp;
    end
  end

  // Read side follows the same rule, no new address while rvalid waits
  assign rd_acc       = axil_arvalid && !axil_rvalid;
  assign axil_arready = rd_acc;

  // Read mux
  // The top snapshot word is only 30 bits wide and zero-filled above
  always_comb begin
    rd_data = '0;
    rd_resp = OKAY;
    case (sscan_reg_e'(axil_ar.addr))
      REG_CTRL: begin
        // Trigger bit is self-clearing and always reads back as 0
        rd_data = '0;
      end
      REG_COUNT: begin
        rd_data = {{(AXIL_DW-CNT_W){1'b0}}, snap_count};
      end
      REG_DATA0: begin
        rd_data = cap_bits[AXIL_DW-1:0];
      end
      REG_DATA1: begin
        rd_data = cap_bits[2*AXIL_DW-1:AXIL_DW];
      end
      REG_DATA2: begin
        rd_data = {{(3*AXIL_DW-SNAP_W){1'b0}}, cap_bits[SNAP_W-1:2*AXIL_DW]};
      end
      default: begin
        rd_resp = SLVERR;
      end
    endcase
  end

  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      axil_rvalid <= 1'b0;
    end else if (rd_acc) begin
      axil_rvalid <= 1'b1;
    end else if (axil_rready) begin
      axil_rvalid <= 1'b0;
    end
  end

  // Read payload is sampled once at accept and held under back-pressure
  always_ff @(posedge rclk) begin
    if (rd_acc) begin
      axil_r.data <= rd_data;
      axil_r.resp <= rd_resp;
    end
  end

endmodule

/* hdl/sscan_top.sv */
// Shadow-scan debug path of one core
// Packs the unit status buses into a snapshot, captures it on a pin or
// software snap, and scans it out serially on the test clock

`timescale 1ns/1ps

module sscan_top
  import sscan_pkg::*;
  import sscan_axi_pkg::*;
(
  input  logic             rclk,
  input  logic             ctu_tck,
  input  logic             rst_n,
  input  logic             ctu_sscan_snap,
  input  logic             ctu_sscan_se,
  input  logic [SWL_W-1:0] swl_sscan_thrstate,
  input  logic [IFQ_W-1:0] ifq_sscan_test_data,
  input  logic [LSU_W-1:0] lsu_sscan_test_data,
  input  logic [TLU_W-1:0] tlu_sscan_test_data,
  input  logic             axil_awvalid,
  output logic             axil_awready,
  input  axil_aw_t         axil_aw,
  input  logic             axil_wvalid,
  output logic             axil_wready,
  input  axil_w_t          axil_w,
  output logic             axil_bvalid,
  input  logic             axil_bready,
  output axil_resp_e       axil_bresp,
  input  logic             axil_arvalid,
  output logic             axil_arready,
  input  axil_ar_t         axil_ar,
  output logic             axil_rvalid,
  input  logic             axil_rready,
  output axil_r_t          axil_r,
  output logic             sparc_sscan_so
);

  sscan_snap_t      status_in;
  sscan_snap_t      cap_data;
  logic             cap_toggle;
  logic [CNT_W-1:0] snap_count;
  logic             sw_snap;
  logic             snap_req;

  // Same bit order as the scan chain, ifq on top
  assign status_in.ifq = ifq_sscan_test_data;
  assign status_in.tlu = tlu_sscan_test_data;
  assign status_in.lsu = lsu_sscan_test_data;
  assign status_in.swl = swl_sscan_thrstate;

  // Both snap sources share one capture path
  assign snap_req = ctu_sscan_snap | sw_snap;

  sscan_snap_capture u_capture (
    .rclk       (rclk),
    .rst_n      (rst_n),
    .snap_req   (snap_req),
    .status_in  (status_in),
    .cap_data   (cap_data),
    .cap_toggle (cap_toggle),
    .snap_count (snap_count)
  );

  sscan_tck_shadow u_shadow (
    .ctu_tck        (ctu_tck),
    .rst_n          (rst_n),
    .ctu_sscan_se   (ctu_sscan_se),
    .cap_toggle     (cap_toggle),
    .cap_data       (cap_data),
    .sparc_sscan_so (sparc_sscan_so)
  );

  sscan_csr_axil u_csr (
    .rclk         (rclk),
    .rst_n        (rst_n),
    .axil_awvalid (axil_awvalid),
    .axil_awready (axil_awready),
    .axil_aw      (axil_aw),
    .axil_wvalid  (axil_wvalid),
    .axil_wready  (axil_wready),
    .axil_w       (axil_w),
    .axil_bvalid  (axil_bvalid),
    .axil_bready  (axil_bready),
    .axil_bresp   (axil_bresp),
    .axil_arvalid (axil_arvalid),
    .axil_arready (axil_arready),
    .axil_ar      (axil_ar),
    .axil_rvalid  (axil_rvalid),
    .axil_rready  (axil_rready),
    .axil_r       (axil_r),
    .cap_data     (cap_data),
    .snap_count   (snap_count),
    .sw_snap      (sw_snap)
  );

endmodule

/* testbench/tb_clocks.sv */
// Clock and reset source of the shadow-scan testbench
// Core clock of 8 ns, test clock of 24 ns and an active-low reset

`timescale 1ns/1ps

module tb_clocks (
  output logic rclk,
  output logic ctu_tck,
  output logic rst_n
);

  initial begin
    rclk = 1'b0;
    forever #4 rclk = ~rclk;
  end

  // Test clock runs three times slower than the core clock
  initial begin
    ctu_tck = 1'b0;
    forever #12 ctu_tck = ~ctu_tck;
  end

  // Reset covers three core clock cycles and is released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge rclk);
    @(negedge rclk);
    rst_n = 1'b1;
  end

endmodule

/* testbench/sscan_asserts.sv */
// Protocol assertions for the shadow-scan top level
// Bound into sscan_top to watch the AXI4-Lite responses and the software snap

`timescale 1ns/1ps

module sscan_asserts (
  input logic rclk,
  input logic rst_n,
  input logic axil_bvalid,
  input logic axil_bready,
  input logic axil_rvalid,
  input logic axil_rready,
  input logic axil_awready,
  input logic sw_snap
);

  // A write response stays up until the master takes it
  a_bvalid_hold: assert property (@(posedge rclk) disable iff (!rst_n)
    axil_bvalid && !axil_bready |=> axil_bvalid)
    else $error("bvalid dropped before bready");

  // Same for the read response
  a_rvalid_hold: assert property (@(posedge rclk) disable iff (!rst_n)
    axil_rvalid && !axil_rready |=> axil_rvalid)
    else $error("rvalid dropped before rready");

  // The software trigger is a single-cycle pulse
  a_sw_snap_pulse: assert property (@(posedge rclk) disable iff (!rst_n)
    sw_snap |=> !sw_snap)
    else $error("sw_snap lasted more than one cycle");

  // No new write is taken while its response is still pending
  // An accepted write or a response held under back-pressure keeps
  // awready low on the following edge
  a_no_aw_with_b: assert property (@(posedge rclk) disable iff (!rst_n)
    (axil_awready || (axil_bvalid && !axil_bready)) |=> !axil_awready)
    else $error("awready high while bvalid pending");

endmodule

/* testbench/sscan_tb.sv */
// Testbench of the shadow-scan debug path
// Random status snapshots are taken by pin and by software, shifted out on
// the test clock and read back over AXI4-Lite, all checked against a model

`timescale 1ns/1ps

module sscan_tb
  import sscan_pkg::*;
  import sscan_axi_pkg::*;
();

  localparam int ROUNDS = 4;
  // One whole scan in rclk cycles, tck is three rclk periods
  localparam int SCAN_CYC = (SNAP_W + 2) * 3;
  // Two scans per round plus snap, settle time and register reads
  localparam int ROUND_CYC = 2 * SCAN_CYC + 150;
  // Rounds plus the error and mid-shift tests, with margin on top
  localparam int TIMEOUT_CYC = (ROUNDS + 2) * ROUND_CYC + 500;

  logic             rclk;
  logic             ctu_tck;
  logic             rst_n;
  logic             ctu_sscan_snap;
  logic             ctu_sscan_se;
  logic [SWL_W-1:0] swl_sscan_thrstate;
  logic [IFQ_W-1:0] ifq_sscan_test_data;
  logic [LSU_W-1:0] lsu_sscan_test_data;
  logic [TLU_W-1:0] tlu_sscan_test_data;
  logic             axil_awvalid;
  logic             axil_awready;
  axil_aw_t         axil_aw;
  logic             axil_wvalid;
  logic             axil_wready;
  axil_w_t          axil_w;
  logic             axil_bvalid;
  logic             axil_bready;
  axil_resp_e       axil_bresp;
  logic             axil_arvalid;
  logic             axil_arready;
  axil_ar_t         axil_ar;
  logic             axil_rvalid;
  logic             axil_rready;
  axil_r_t          axil_r;
  logic             sparc_sscan_so;

  // Model state, the last frozen snapshot and the number of snaps so far
  sscan_snap_t exp_snap;
  int          exp_count;
  int          fails;
  int          cycles = 0;
  logic [15:0] lfsr;

  tb_clocks u_clocks (.rclk(rclk), .ctu_tck(ctu_tck), .rst_n(rst_n));

  sscan_top u_sscan_top (.*);

  bind sscan_top sscan_asserts u_asserts (
    .rclk(rclk), .rst_n(rst_n), .axil_bvalid(axil_bvalid), .axil_bready(axil_bready),
    .axil_rvalid(axil_rvalid), .axil_rready(axil_rready),
    .axil_awready(axil_awready), .sw_snap(sw_snap)
  );

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      fails++;
      $display("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit drawn
  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  // New random status, held for four cycles before anything may snap it
  task automatic hold_status();
    logic [63:0] v;
    @(negedge rclk);
    draw_bits(IFQ_W, v);
    ifq_sscan_test_data = v[IFQ_W-1:0];
    draw_bits(TLU_W, v);
    tlu_sscan_test_data = v[TLU_W-1:0];
    draw_bits(LSU_W, v);
    lsu_sscan_test_data = v[LSU_W-1:0];
    draw_bits(SWL_W, v);
    swl_sscan_thrstate = v[SWL_W-1:0];
    repeat (4) @(negedge rclk);
  endtask

  // Snapshot order from the MSB is ifq, tlu, lsu, thread state
  task automatic snap_model();
    exp_snap = {ifq_sscan_test_data, tlu_sscan_test_data,
                lsu_sscan_test_data, swl_sscan_thrstate};
    exp_count++;
  endtask

  // One AXI4-Lite transfer with a random stretch of response back-pressure
  task automatic bus_op(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output axil_resp_e resp);
    logic [63:0] gap;
    @(negedge rclk);
    if (wr) begin
      axil_awvalid = 1'b1;
      axil_aw.addr = addr;
      axil_wvalid  = 1'b1;
      axil_w.data  = wdata;
      axil_w.strb  = 4'hf;
    end else begin
      axil_arvalid = 1'b1;
      axil_ar.addr = addr;
    end
    // Ready is combinational, so look at it once the inputs have settled
    #1;
    while (!(wr ? axil_awready : axil_arready)) begin
      @(negedge rclk);
      #1;
    end
    // Address and data of a write are taken in the same cycle
    if (wr) check_value(axil_wready, 1'b1, "wready together with awready");
    @(negedge rclk);
    axil_awvalid = 1'b0;
    axil_wvalid  = 1'b0;
    axil_arvalid = 1'b0;
    rdata = axil_r.data;
    resp  = wr ? axil_bresp : axil_r.resp;
    draw_bits(3, gap);
    for (int i = 0; i <= int'(gap[2:0]); i++) begin
      check_value(wr ? axil_bvalid : axil_rvalid, 1'b1, "response valid held");
      check_value(wr ? axil_bresp : axil_r.resp, resp, "response code held");
      check_value(axil_r.data, rdata, "read data held");
      if (i < int'(gap[2:0])) @(negedge rclk);
    end
    axil_bready = wr;
    axil_rready = !wr;
    @(negedge rclk);
    axil_bready = 1'b0;
    axil_rready = 1'b0;
    check_value(wr ? axil_bvalid : axil_rvalid, 1'b0, "one response per request");
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input axil_resp_e exp_resp, input string what);
    logic [31:0] rdata;
    axil_resp_e  resp;
    bus_op(1'b1, addr, data, rdata, resp);
    check_value(resp, exp_resp, what);
  endtask

  // Read data only matters on an OKAY response
  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp_data,
                             input axil_resp_e exp_resp, input string what);
    logic [31:0] rdata;
    axil_resp_e  resp;
    bus_op(1'b0, addr, 32'h0, rdata, resp);
    check_value(resp, exp_resp, {what, " response"});
    if (exp_resp == OKAY) check_value(rdata, exp_data, what);
  endtask

  task automatic pin_snap();
    hold_status();
    ctu_sscan_snap = 1'b1;
    @(negedge rclk);
    ctu_sscan_snap = 1'b0;
    repeat (2) @(negedge rclk);
    snap_model();
  endtask

  task automatic soft_snap();
    hold_status();
    write_reg(REG_CTRL, 32'h1, OKAY, "CTRL snap write");
    snap_model();
  endtask

  // Snapshot words and count, DATA2 holds bits 93:64 zero-extended
  task automatic data_check(input string what);
    logic [SNAP_W-1:0] bits;
    bits = exp_snap;
    read_expect(REG_DATA0, bits[31:0], OKAY, {what, ", DATA0"});
    read_expect(REG_DATA1, bits[63:32], OKAY, {what, ", DATA1"});
    read_expect(REG_DATA2, {2'b00, bits[93:64]}, OKAY, {what, ", DATA2"});
    read_expect(REG_COUNT, exp_count, OKAY, {what, ", COUNT"});
  endtask

  // so is sampled on the falling tck edge, MSB first, then se drops again
  task automatic scan_check(input sscan_snap_t exp, input string what);
    logic [SNAP_W-1:0] bits;
    bits = exp;
    for (int i = SNAP_W - 1; i >= 0; i--) begin
      @(negedge ctu_tck);
      check_value(sparc_sscan_so, bits[i], $sformatf("%s, bit %0d", what, i));
      if (i == SNAP_W - 1) ctu_sscan_se = 1'b1;
    end
    @(negedge ctu_tck);
    ctu_sscan_se = 1'b0;
  endtask

  always @(posedge rclk) begin
    cycles++;
    if (cycles > TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d rclk cycles", TIMEOUT_CYC);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  initial begin
    lfsr = 16'd91;
    ctu_sscan_snap = 1'b0;
    ctu_sscan_se = 1'b0;
    swl_sscan_thrstate = '0;
    ifq_sscan_test_data = '0;
    lsu_sscan_test_data = '0;
    tlu_sscan_test_data = '0;
    axil_awvalid = 1'b0;
    axil_aw = '0;
    axil_wvalid = 1'b0;
    axil_w = '0;
    axil_bready = 1'b0;
    axil_arvalid = 1'b0;
    axil_ar = '0;
    axil_rready = 1'b0;
    exp_snap = '0;
    exp_count = 0;
    fails = 0;
    @(posedge rst_n);
    @(negedge rclk);
    check_value(sparc_sscan_so, 1'b0, "scan out after reset");
    check_value(axil_bvalid, 1'b0, "bvalid after reset");
    check_value(axil_rvalid, 1'b0, "rvalid after reset");
    check_value(axil_awready, 1'b0, "awready after reset");
    check_value(axil_wready, 1'b0, "wready after reset");
    check_value(axil_arready, 1'b0, "arready after reset");
    data_check("after reset");

    // Pin and software snaps take turns, each is shifted out and read back
    for (int r = 0; r < ROUNDS; r++) begin
      if (r % 2 == 0) pin_snap();
      else soft_snap();
      repeat (6) @(negedge ctu_tck);
      scan_check(exp_snap, "snapshot shift");
      scan_check('0, "shift after a full scan");
      data_check("snapshot readout");
    end

    // Fresh status without a snap, so a stray capture would show in the data
    hold_status();
    read_expect(8'h14, 32'h0, SLVERR, "unmapped read");
    write_reg(REG_COUNT, 32'h1, SLVERR, "COUNT write");
    write_reg(8'h40, 32'h1, SLVERR, "unmapped write");
    write_reg(REG_CTRL, 32'h0, OKAY, "CTRL write with bit 0 clear");
    data_check("after rejected writes");

    // A snap lands mid-shift and must wait for the next scan
    pin_snap();
    repeat (6) @(negedge ctu_tck);
    fork
      scan_check(exp_snap, "shift with a snap in flight");
      begin
        repeat (20) @(negedge ctu_tck);
        pin_snap();
      end
    join
    repeat (6) @(negedge ctu_tck);
    scan_check(exp_snap, "snap taken during a shift");
    data_check("after mid-shift snap");

    if (fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* src.f */
hdl/sscan_pkg.sv
hdl/sscan_axi_pkg.sv
hdl/sscan_snap_capture.sv
hdl/sscan_tck_shadow.sv
hdl/sscan_csr_axil.sv
hdl/sscan_top.sv
testbench/tb_clocks.sv
testbench/sscan_asserts.sv
testbench/sscan_tb.sv

/* Makefile */
# Verilator simulation of the shadow-scan testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass message in sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	rm -rf obj_dir sim.log
	verilator --binary --timing --assert -Wno-fatal --top-module sscan_tb -f src.f -o sscan_sim
	./obj_dir/sscan_sim | tee sim.log
	grep -qxF "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log
